/* src/hdc_config.svh */
`ifndef HDC_CONFIG_SVH
`define HDC_CONFIG_SVH

// ------------------------------
// axi-lite bus
// ------------------------------
`define HDC_AXIL_ADDR_W 32
`define HDC_AXIL_DATA_W 32

// ------------------------------
// item generation
// ------------------------------
// 32-bit words per hypervector, 1 to 32
`define HDC_HV_WORDS 1
// item memory depth is 2**this
`define HDC_ITEM_ADDR_W 10
// xorshift start value, shared with the model
`define HDC_PRNG_SEED 32'd2463534242

// register byte offsets inside the 1 KB window
`define HDC_REG_MODE 10'h000
`define HDC_REG_COUNT 10'h004

`endif

/* src/hdc_pkg.sv */
`include "hdc_config.svh"

package hdc_pkg;

    // ------------------------------
    // bus words
    // ------------------------------
    typedef logic [`HDC_AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [`HDC_AXIL_DATA_W-1:0] axil_data_t;

    // ------------------------------
    // item memory side
    // ------------------------------
    typedef logic [`HDC_ITEM_ADDR_W-1:0] item_addr_t;
    // one prng output
    typedef logic [31:0] hv_word_t;
    // full vector, word 0 in the low bits
    typedef logic [`HDC_HV_WORDS*32-1:0] hv_t;
    // position of a word inside the vector
    typedef logic [4:0] word_idx_t;

    // axi-lite slave states
    typedef enum logic [2:0] {
        IDLE,
        GOT_AW,
        GOT_W,
        WRITE_RESP,
        READ_FETCH,
        READ_RESP
    } axil_state_t;

endpackage

/* src/axil_slave.sv */
`timescale 1ns/10ps
`include "hdc_config.svh"

module axil_slave import hdc_pkg::*; (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,
    // write address
    input  axil_addr_t                      s_axi_awaddr,
    input  logic                            s_axi_awvalid,
    output logic                            s_axi_awready,
    // write data
    input  axil_data_t                      s_axi_wdata,
    input  logic [`HDC_AXIL_DATA_W/8-1:0]   s_axi_wstrb,
    input  logic                            s_axi_wvalid,
    output logic                            s_axi_wready,
    // write response
    output logic [1:0]                      s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  logic                            s_axi_bready,
    // read address
    input  axil_addr_t                      s_axi_araddr,
    input  logic                            s_axi_arvalid,
    output logic                            s_axi_arready,
    // read data
    output axil_data_t                      s_axi_rdata,
    output logic [1:0]                      s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  logic                            s_axi_rready,
    // register file side
    output logic                            reg_wr,
    output logic [7:0]                      reg_addr,
    output axil_data_t                      reg_wdata,
    output logic                            reg_rd,
    input  axil_data_t                      reg_rdata
);

    axil_state_t                    state;
    axil_state_t                    state_nxt;
    // word-aligned offsets, bits 11:10 select the window
    logic [11:2]                    wr_addr;
    logic [11:2]                    rd_addr;
    axil_data_t                     wr_data;
    logic [`HDC_AXIL_DATA_W/8-1:0]  wr_strb;
    logic                           aw_hs;
    logic                           w_hs;
    logic                           ar_hs;
    logic                           wr_enter;
    logic                           wr_hit;
    logic [11:2]                    awaddr_nxt;
    logic [`HDC_AXIL_DATA_W/8-1:0]  wstrb_nxt;

    // ------------------------------
    // channel handshakes
    // ------------------------------
    assign s_axi_awready = (state == IDLE) | (state == GOT_W);
    assign s_axi_wready = (state == IDLE) | (state == GOT_AW);
    // a pending write wins over a read in idle
    assign s_axi_arready = (state == IDLE) & ~s_axi_awvalid & ~s_axi_wvalid;
    assign s_axi_bvalid = (state == WRITE_RESP);
    assign s_axi_rvalid = (state == READ_RESP);
    // always okay
    assign s_axi_bresp = 2'b00;
    assign s_axi_rresp = 2'b00;

    assign aw_hs = s_axi_awvalid & s_axi_awready;
    assign w_hs = s_axi_wvalid & s_axi_wready;
    assign ar_hs = s_axi_arvalid & s_axi_arready;

    // both halves of the write present after this edge
    assign wr_enter = (aw_hs | (state == GOT_AW)) & (w_hs | (state == GOT_W));
    // address and strobe as they stand after this edge
    assign awaddr_nxt = aw_hs ? s_axi_awaddr[11:2] : wr_addr;
    assign wstrb_nxt = w_hs ? s_axi_wstrb : wr_strb;
    // in window and at least one byte lane enabled
    assign wr_hit = wr_enter & (awaddr_nxt[11:10] == 2'b00) & (|wstrb_nxt);

    // ------------------------------
    // state machine
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (aw_hs && w_hs) begin
                    state_nxt = WRITE_RESP;
                end else if (aw_hs) begin
                    state_nxt = GOT_AW;
                end else if (w_hs) begin
                    state_nxt = GOT_W;
                end else if (ar_hs) begin
                    state_nxt = READ_FETCH;
                end
            end
            GOT_AW: begin
                if (w_hs) begin
                    state_nxt = WRITE_RESP;
                end
            end
            GOT_W: begin
                if (aw_hs) begin
                    state_nxt = WRITE_RESP;
                end
            end
            WRITE_RESP: begin
                if (s_axi_bready) begin
                    state_nxt = IDLE;
                end
            end
            // register fetch takes one cycle
            READ_FETCH: state_nxt = READ_RESP;
            READ_RESP: begin
                if (s_axi_rready) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= IDLE;
            reg_wr <= 1'b0;
        end else begin
            state <= state_nxt;
            // single pulse, first cycle of WRITE_RESP
            reg_wr <= wr_hit;
        end
    end

    // ------------------------------
    // address and data capture
    // ------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (aw_hs) begin
            wr_addr <= s_axi_awaddr[11:2];
        end
        if (w_hs) begin
            wr_data <= s_axi_wdata;
            wr_strb <= s_axi_wstrb;
        end
        if (ar_hs) begin
            rd_addr <= s_axi_araddr[11:2];
        end
        // held through READ_RESP until rready
        if (state == READ_FETCH) begin
            s_axi_rdata <= reg_rdata;
        end
    end

    // out-of-window reads leave reg_rd low and fetch zero
    assign reg_rd = (state == READ_FETCH) & (rd_addr[11:10] == 2'b00);
    assign reg_addr = (state == READ_FETCH) ? rd_addr[9:2] : wr_addr[9:2];
    assign reg_wdata = wr_data;

endmodule

/* src/hdc_mode_regs.sv */
`timescale 1ns/10ps
`include "hdc_config.svh"

module hdc_mode_regs import hdc_pkg::*; (
    input  logic        AXIS_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic        reg_wr,
    input  logic [7:0]  reg_addr,
    input  axil_data_t  reg_wdata,
    input  logic        reg_rd,
    output axil_data_t  reg_rdata,
    input  logic        gen_done,
    output logic        mode_gen,
    output logic        mode_run,
    output item_addr_t  item_count
);

    // byte offset rebuilt from the word offset
    logic [9:0]     byte_off;
    logic           wr_mode;
    logic           wr_count;

    assign byte_off = {reg_addr, 2'b00};
    assign wr_mode = reg_wr & (byte_off == `HDC_REG_MODE);
    assign wr_count = reg_wr & (byte_off == `HDC_REG_COUNT);

    // ------------------------------
    // register writes
    // ------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            mode_gen <= 1'b0;
            mode_run <= 1'b0;
            item_count <= '0;
        end else begin
            // bit 0 gen, bit 1 run
            if (wr_mode) begin
                mode_gen <= reg_wdata[0];
                mode_run <= reg_wdata[1];
            end else if (gen_done) begin
                // last item written, generation ends by itself
                mode_gen <= 1'b0;
            end
            if (wr_count) begin
                item_count <= reg_wdata[`HDC_ITEM_ADDR_W-1:0];
            end
        end
    end

    // ------------------------------
    // read mux
    // ------------------------------
    // unused bits and unmapped offsets return zero
    always_comb begin
        reg_rdata = '0;
        if (reg_rd) begin
            case (byte_off)
                `HDC_REG_MODE: reg_rdata[1:0] = {mode_run, mode_gen};
                `HDC_REG_COUNT: reg_rdata[`HDC_ITEM_ADDR_W-1:0] = item_count;
                default: reg_rdata = '0;
            endcase
        end
    end

endmodule

/* src/xorshift32.sv */
`timescale 1ns/10ps
`include "hdc_config.svh"

module xorshift32 import hdc_pkg::*; (
    input  logic        AXIS_ACLK,
    input  logic        mode_gen,
    output hv_word_t    rand_word
);

    // shift-xor chain, 13 left / 17 right / 5 left
    hv_word_t   step_a;
    hv_word_t   step_b;
    hv_word_t   step_c;

    assign step_a = rand_word ^ (rand_word << 13);
    assign step_b = step_a ^ (step_a >> 17);
    assign step_c = step_b ^ (step_b << 5);

    // seed held while idle, so every run repeats the same sequence
    always_ff @(posedge AXIS_ACLK) begin
        if (!mode_gen) begin
            rand_word <= `HDC_PRNG_SEED;
        end else begin
            // one step per generation cycle
            rand_word <= step_c;
        end
    end

endmodule

/* src/item_vector_gen.sv */
`timescale 1ns/10ps
`include "hdc_config.svh"

module item_vector_gen import hdc_pkg::*; (
    input  logic        AXIS_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic        mode_gen,
    input  item_addr_t  item_count,
    output logic        item_wr,
    output item_addr_t  item_addr,
    output hv_t         item_vec,
    output logic        gen_done
);

    localparam word_idx_t LAST_IDX = word_idx_t'(`HDC_HV_WORDS - 1);

    hv_word_t   rand_word;
    word_idx_t  word_idx;
    // vector complete, write strobe before mode gating
    logic       wr_q;
    logic       last_word;

    // current state of the generator, seed on the first cycle
    xorshift32 prng_inst (
        .AXIS_ACLK (AXIS_ACLK),
        .mode_gen  (mode_gen),
        .rand_word (rand_word)
    );

    assign last_word = (word_idx == LAST_IDX);

    // ------------------------------
    // word sequencer and address
    // ------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !mode_gen) begin
            word_idx <= '0;
            wr_q <= 1'b0;
            item_addr <= '0;
        end else begin
            // wraps after the last word of a vector
            word_idx <= last_word ? '0 : word_idx + 1'b1;
            // strobe follows capture of the last word
            wr_q <= last_word;
            // next item address once this one is written
            if (wr_q) begin
                item_addr <= item_addr + 1'b1;
            end
        end
    end

    // ------------------------------
    // vector assembly
    // ------------------------------
    for (genvar j = 0; j < `HDC_HV_WORDS; j++) begin : g_word
        always_ff @(posedge AXIS_ACLK) begin
            // word j lands in bits j*32 upward
            if (mode_gen && word_idx == word_idx_t'(j)) begin
                item_vec[j*32 +: 32] <= rand_word;
            end
        end
    end

    // no strobe in the cycle after gen clears
    assign item_wr = wr_q & mode_gen;
    // last item is the one at address item_count
    assign gen_done = item_wr & (item_addr == item_count);

endmodule

/* src/hdc_item_top.sv */
`timescale 1ns/10ps
`include "hdc_config.svh"

module hdc_item_top import hdc_pkg::*; (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,
    // axi-lite control port
    input  axil_addr_t                      s_axi_awaddr,
    input  logic                            s_axi_awvalid,
    output logic                            s_axi_awready,
    input  axil_data_t                      s_axi_wdata,
    input  logic [`HDC_AXIL_DATA_W/8-1:0]   s_axi_wstrb,
    input  logic                            s_axi_wvalid,
    output logic                            s_axi_wready,
    output logic [1:0]                      s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  logic                            s_axi_bready,
    input  axil_addr_t                      s_axi_araddr,
    input  logic                            s_axi_arvalid,
    output logic                            s_axi_arready,
    output axil_data_t                      s_axi_rdata,
    output logic [1:0]                      s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  logic                            s_axi_rready,
    // mode levels to the encoder cores
    output logic                            gen,
    output logic                            run,
    // item memory write port
    output logic                            item_wr,
    output item_addr_t                      item_addr,
    output hv_t                             item_vec
);

    // ------------------------------
    // internal wiring
    // ------------------------------
    logic           reg_wr;
    logic [7:0]     reg_addr;
    axil_data_t     reg_wdata;
    logic           reg_rd;
    axil_data_t     reg_rdata;
    logic           gen_done;
    item_addr_t     item_count;

    // bus handshakes to register strobes
    axil_slave axil_slave_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rd        (reg_rd),
        .reg_rdata     (reg_rdata)
    );

    // mode and count registers
    hdc_mode_regs hdc_mode_regs_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rd        (reg_rd),
        .reg_rdata     (reg_rdata),
        .gen_done      (gen_done),
        .mode_gen      (gen),
        .mode_run      (run),
        .item_count    (item_count)
    );

    // random item vectors while gen is set
    item_vector_gen item_vector_gen_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .mode_gen      (gen),
        .item_count    (item_count),
        .item_wr       (item_wr),
        .item_addr     (item_addr),
        .item_vec      (item_vec),
        .gen_done      (gen_done)
    );

endmodule

/* verif/hdc_item_checker.sv */
`timescale 1ns/10ps

module hdc_item_checker import hdc_pkg::*; (
    input logic         AXIS_ACLK,
    input logic         S_AXI_ARESETN,
    input logic         s_axi_bvalid,
    input logic         s_axi_bready,
    input logic         s_axi_rvalid,
    input logic         s_axi_rready,
    input axil_data_t   s_axi_rdata,
    input logic         gen,
    input logic         item_wr,
    input item_addr_t   item_addr
);

    // one counter per property, summed for the testbench
    int         bhold_fails = 0;
    int         rhold_fails = 0;
    int         wr_fails = 0;
    int         step_fails = 0;
    int         fail_count;
    // address of the previous strobe in this generation
    item_addr_t prev_addr;
    logic       seen_wr;

    assign fail_count = bhold_fails + rhold_fails + wr_fails + step_fails;

    // ------------------------------
    // strobe history
    // ------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            seen_wr <= 1'b0;
        end else if (item_wr) begin
            seen_wr <= 1'b1;
            prev_addr <= item_addr;
        end
    end

    // responses wait for the master
    bvalid_held: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else begin
            $error("BVALID dropped before BREADY");
            bhold_fails++;
        end

    rvalid_held: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
        else begin
            $error("RVALID or RDATA changed before RREADY");
            rhold_fails++;
        end

    // item writes only during generation
    wr_in_gen: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        item_wr |-> gen)
        else begin
            $error("item_wr while gen is low");
            wr_fails++;
        end

    addr_step: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        item_wr && seen_wr |-> item_addr == prev_addr + 1'b1)
        else begin
            $error("item_addr did not step by one");
            step_fails++;
        end

endmodule

bind hdc_item_top hdc_item_checker hdc_item_checker_inst (
    .AXIS_ACLK     (AXIS_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .s_axi_rdata   (s_axi_rdata),
    .gen           (gen),
    .item_wr       (item_wr),
    .item_addr     (item_addr)
);

/* verif/hdc_item_tb.sv */
`timescale 1ns/10ps
`include "hdc_config.svh"

module hdc_item_tb import hdc_pkg::*; ();

    localparam int TIMEOUT = 2000;
    localparam axil_addr_t MODE_ADDR = axil_addr_t'(`HDC_REG_MODE);
    localparam axil_addr_t COUNT_ADDR = axil_addr_t'(`HDC_REG_COUNT);

    logic                           AXIS_ACLK;
    logic                           S_AXI_ARESETN;
    axil_addr_t                     s_axi_awaddr;
    logic                           s_axi_awvalid;
    logic                           s_axi_awready;
    axil_data_t                     s_axi_wdata;
    logic [`HDC_AXIL_DATA_W/8-1:0]  s_axi_wstrb;
    logic                           s_axi_wvalid;
    logic                           s_axi_wready;
    logic [1:0]                     s_axi_bresp;
    logic                           s_axi_bvalid;
    logic                           s_axi_bready;
    axil_addr_t                     s_axi_araddr;
    logic                           s_axi_arvalid;
    logic                           s_axi_arready;
    axil_data_t                     s_axi_rdata;
    logic [1:0]                     s_axi_rresp;
    logic                           s_axi_rvalid;
    logic                           s_axi_rready;
    logic                           gen;
    logic                           run;
    logic                           item_wr;
    item_addr_t                     item_addr;
    hv_t                            item_vec;

    logic [31:0]    rng_state;
    string          test_name;
    int             test_errors;
    int             total_errors;
    int             tests_run;
    int             b_accepts = 0;
    int             r_accepts = 0;
    item_addr_t     wr_addrs[$];
    hv_t            wr_vecs[$];

    hdc_item_top hdc_item_top_inst (.*);

    initial AXIS_ACLK = 1'b0;
    always #10 AXIS_ACLK = ~AXIS_ACLK;

    // ------------------------------
    // monitors sampled mid-cycle
    // ------------------------------
    always @(negedge AXIS_ACLK) begin
        if (S_AXI_ARESETN) begin
            if (s_axi_bvalid && s_axi_bready) begin
                b_accepts++;
            end
            if (s_axi_rvalid && s_axi_rready) begin
                r_accepts++;
            end
            if (item_wr) begin
                wr_addrs.push_back(item_addr);
                wr_vecs.push_back(item_vec);
            end
        end
    end

    // stimulus prng with shifts 13 / 17 / 5
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // reference generator step
    function automatic hv_word_t model_next(input hv_word_t s);
        hv_word_t t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        return t ^ (t << 5);
    endfunction

    task automatic expect_word(input string what, input axil_data_t exp,
                               input axil_data_t act);
        assert (act === exp) else begin
            $display("FAILED %s %s: expected 0x%0h actual 0x%0h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic expect_vec(input string what, input hv_t exp, input hv_t act);
        assert (act === exp) else begin
            $display("FAILED %s %s: expected 0x%0h actual 0x%0h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout in %s while waiting for %s", test_name, what);
        $display("test failed");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("%s finished with %0d errors", test_name, test_errors);
        total_errors += test_errors;
        tests_run++;
    endtask

    // ------------------------------
    // bus tasks
    // ------------------------------
    // order 0 sends aw first, 1 sends w first and 2 sends both together
    task automatic bus_write(input axil_addr_t addr, input axil_data_t data,
                             input int order, input int stall);
        logic aw_left;
        logic w_left;
        int   n;
        aw_left = 1'b1;
        w_left = 1'b1;
        n = 0;
        @(posedge AXIS_ACLK);
        #1;
        s_axi_awaddr = addr;
        s_axi_wdata = data;
        while (aw_left || w_left) begin
            s_axi_awvalid = aw_left && (order != 1 || !w_left);
            s_axi_wvalid = w_left && (order != 0 || !aw_left);
            if (n == TIMEOUT) begin
                give_up("AWREADY and WREADY");
            end
            n++;
            @(negedge AXIS_ACLK);
            if (s_axi_awvalid && s_axi_awready) begin
                aw_left = 1'b0;
            end
            if (s_axi_wvalid && s_axi_wready) begin
                w_left = 1'b0;
            end
            @(posedge AXIS_ACLK);
            #1;
        end
        s_axi_awvalid = 1'b0;
        s_axi_wvalid = 1'b0;
        n = 0;
        do begin
            if (n == TIMEOUT) begin
                give_up("BVALID");
            end
            n++;
            @(negedge AXIS_ACLK);
        end while (!s_axi_bvalid);
        // okay response
        expect_word("BRESP", 0, axil_data_t'(s_axi_bresp));
        // bready held low so the response stays pending
        repeat (stall) begin
            @(negedge AXIS_ACLK);
            expect_word("BVALID held", 1, axil_data_t'(s_axi_bvalid));
        end
        @(posedge AXIS_ACLK);
        #1;
        s_axi_bready = 1'b1;
        @(posedge AXIS_ACLK);
        #1;
        s_axi_bready = 1'b0;
    endtask

    task automatic bus_read(input axil_addr_t addr, input int stall, output axil_data_t data);
        int n;
        @(posedge AXIS_ACLK);
        #1;
        s_axi_araddr = addr;
        s_axi_arvalid = 1'b1;
        n = 0;
        do begin
            if (n == TIMEOUT) begin
                give_up("ARREADY");
            end
            n++;
            @(negedge AXIS_ACLK);
        end while (!s_axi_arready);
        @(posedge AXIS_ACLK);
        #1;
        s_axi_arvalid = 1'b0;
        n = 0;
        do begin
            if (n == TIMEOUT) begin
                give_up("RVALID");
            end
            n++;
            @(negedge AXIS_ACLK);
        end while (!s_axi_rvalid);
        data = s_axi_rdata;
        // okay response
        expect_word("RRESP", 0, axil_data_t'(s_axi_rresp));
        // data must not move while rready is low
        repeat (stall) begin
            @(negedge AXIS_ACLK);
            expect_word("RVALID held", 1, axil_data_t'(s_axi_rvalid));
            expect_word("RDATA held", data, s_axi_rdata);
        end
        @(posedge AXIS_ACLK);
        #1;
        s_axi_rready = 1'b1;
        @(posedge AXIS_ACLK);
        #1;
        s_axi_rready = 1'b0;
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    initial begin
        axil_data_t rd;
        axil_data_t val;
        hv_word_t   model;
        hv_t        exp_vec;
        int         n_items;
        int         order;
        int         stall_b;
        int         stall_r;
        int         first;
        int         b_base;
        int         r_base;
        int         n;
        int         j;
        int         k;
        int         sva_errors;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wstrb = '1;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b0;
        s_axi_araddr = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b0;
        rng_state = 32'd3041;
        total_errors = 0;
        tests_run = 0;
        repeat (5) @(posedge AXIS_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;

        start_test("reset_state");
        @(negedge AXIS_ACLK);
        expect_word("gen", 0, axil_data_t'(gen));
        expect_word("run", 0, axil_data_t'(run));
        expect_word("item_wr", 0, axil_data_t'(item_wr));
        expect_word("BVALID", 0, axil_data_t'(s_axi_bvalid));
        expect_word("RVALID", 0, axil_data_t'(s_axi_rvalid));
        bus_read(MODE_ADDR, 0, rd);
        expect_word("mode reg", 0, rd);
        bus_read(COUNT_ADDR, 0, rd);
        expect_word("count reg", 0, rd);
        end_test();

        start_test("reg_access");
        // random upper bits get dropped by the registers
        val = next_random();
        bus_write(COUNT_ADDR, val, 2, 0);
        bus_write(MODE_ADDR, (next_random() | 32'h2) & ~32'h1, 2, 0);
        bus_read(COUNT_ADDR, 0, rd);
        expect_word("count reg", val & 32'h3ff, rd);
        bus_read(MODE_ADDR, 0, rd);
        expect_word("mode reg", 32'h2, rd);
        expect_word("run", 1, axil_data_t'(run));
        // writes outside the map land nowhere
        bus_write(32'h8, next_random(), 2, 0);
        bus_write(32'h404, next_random(), 2, 0);
        bus_read(32'h8, 0, rd);
        expect_word("offset 0x8", 0, rd);
        bus_read(32'h404, 0, rd);
        expect_word("offset 0x404", 0, rd);
        bus_read(COUNT_ADDR, 0, rd);
        expect_word("count kept", val & 32'h3ff, rd);
        bus_read(MODE_ADDR, 0, rd);
        expect_word("mode kept", 32'h2, rd);
        end_test();

        start_test("channel_order");
        for (order = 0; order < 3; order++) begin
            val = next_random() & 32'h3ff;
            b_base = b_accepts;
            bus_write(COUNT_ADDR, val, order, 0);
            expect_word("B responses", 1, axil_data_t'(b_accepts - b_base));
            bus_read(COUNT_ADDR, 0, rd);
            expect_word("count reg", val, rd);
        end
        end_test();

        start_test("generation");
        repeat (2) begin
            n_items = int'(next_random() % 64);
            order = int'(next_random() % 3);
            first = wr_addrs.size();
            bus_write(COUNT_ADDR, axil_data_t'(n_items), order, 0);
            bus_write(MODE_ADDR, 32'h1, order, 0);
            // gen clears itself after the last item
            n = 0;
            do begin
                if (n == TIMEOUT) begin
                    give_up("gen to clear");
                end
                n++;
                @(negedge AXIS_ACLK);
            end while (gen);
            expect_word("item_wr pulses", axil_data_t'(n_items + 1),
                        axil_data_t'(wr_addrs.size() - first));
            // word j of item k is state k*words+j with the seed as state 0
            model = `HDC_PRNG_SEED;
            for (k = 0; first + k < wr_addrs.size(); k++) begin
                for (j = 0; j < `HDC_HV_WORDS; j++) begin
                    exp_vec[j*32 +: 32] = model;
                    model = model_next(model);
                end
                expect_word("item_addr", axil_data_t'(k), axil_data_t'(wr_addrs[first + k]));
                expect_vec("item_vec", exp_vec, wr_vecs[first + k]);
            end
            bus_read(MODE_ADDR, 0, rd);
            expect_word("mode after gen", 0, rd);
        end
        end_test();

        start_test("back_pressure");
        b_base = b_accepts;
        r_base = r_accepts;
        repeat (4) begin
            val = next_random() & 32'h3ff;
            order = int'(next_random() % 3);
            stall_b = int'(next_random() % 8) + 1;
            stall_r = int'(next_random() % 8) + 1;
            bus_write(COUNT_ADDR, val, order, stall_b);
            bus_read(COUNT_ADDR, stall_r, rd);
            expect_word("count reg", val, rd);
        end
        expect_word("B accepts", 4, axil_data_t'(b_accepts - b_base));
        expect_word("R accepts", 4, axil_data_t'(r_accepts - r_base));
        end_test();

        sva_errors = hdc_item_top_inst.hdc_item_checker_inst.fail_count;
        $display("%0d tests, %0d check errors, %0d assertion errors",
                 tests_run, total_errors, sva_errors);
        if (total_errors == 0 && sva_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/hdc_pkg.sv
src/axil_slave.sv
src/hdc_mode_regs.sv
src/xorshift32.sv
src/item_vector_gen.sv
src/hdc_item_top.sv
verif/hdc_item_checker.sv
verif/hdc_item_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module hdc_item_tb -o hdc_item_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/hdc_item_sim +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
